// ==== logic/rv_isa_pkg.sv ====
package rv_isa_pkg;

	// Integer ALU operations
	typedef enum logic [3:0] {
		alu_add    = 4'h0,
		alu_sub    = 4'h1,
		alu_sll    = 4'h2,
		alu_slt    = 4'h3,
		alu_sltu   = 4'h4,
		alu_xor    = 4'h5,
		alu_srl    = 4'h6,
		alu_sra    = 4'h7,
		alu_or     = 4'h8,
		alu_and    = 4'h9,
		alu_pass_b = 4'ha // LUI
	} alu_op_e;

	typedef enum logic [1:0] {
		m_mul    = 2'b00,
		m_mulh   = 2'b01,
		m_mulhsu = 2'b10,
		m_mulhu  = 2'b11
	} mul_op_e;

	// Low bits pick the compare, bit 2 inverts it
	typedef enum logic [2:0] {
		br_none = 3'b000,
		br_eq   = 3'b001,
		br_lt   = 3'b010,
		br_ltu  = 3'b011,
		br_ne   = 3'b101,
		br_ge   = 3'b110,
		br_geu  = 3'b111
	} branch_e;

	typedef enum logic [2:0] {
		ld_none = 3'd0,
		ld_lb   = 3'd1,
		ld_lh   = 3'd2,
		ld_lw   = 3'd3,
		ld_lbu  = 3'd4,
		ld_lhu  = 3'd5
	} load_e;

	typedef enum logic [1:0] {
		st_none = 2'b00,
		st_sw   = 2'b01,
		st_sh   = 2'b10,
		st_sb   = 2'b11
	} store_e;

endpackage

// ==== logic/ex_stage_pkg.sv ====
package ex_stage_pkg;

	import rv_isa_pkg::*;

	typedef enum logic [3:0] {
		cls_alu_rr   = 4'd0,
		cls_alu_ri   = 4'd1,
		cls_lui      = 4'd2,
		cls_auipc    = 4'd3,
		cls_jal_link = 4'd4, // JAL and JALR, writes PC+4
		cls_mul      = 4'd5,
		cls_load     = 4'd6,
		cls_store    = 4'd7,
		cls_branch   = 4'd8
	} ex_class_e;

	typedef enum logic [1:0] {
		fwd_reg = 2'b00,
		fwd_mem = 2'b01,
		fwd_wb  = 2'b10
	} fwd_sel_e;

	typedef enum logic [1:0] {
		res_alu  = 2'b00,
		res_mul  = 2'b01,
		res_link = 2'b10
	} result_sel_e;

	typedef struct packed {
		ex_class_e  cls;
		alu_op_e    alu_op;
		mul_op_e    mul_op;
		branch_e    branch;
		load_e      load;
		store_e     store;
		fwd_sel_e   fwd_a;
		fwd_sel_e   fwd_b;
		logic [4:0] rd;
		logic       wb_en;
	} ex_ctrl_t;

	typedef struct packed {
		logic [31:0] pc;
		logic [31:0] rs1_data;
		logic [31:0] rs2_data;
		logic [31:0] imm;
		logic [31:0] fwd_mem; // Result held in MEM
		logic [31:0] fwd_wb;  // Result held in WB
	} ex_operands_t;

	typedef struct packed {
		logic [31:0] result;
		logic [4:0]  rd;
		logic        wb_en;
		load_e       load;
	} mem_stage_t;

	typedef struct packed {
		logic [31:0] addr;
		logic [31:0] data;
		logic [31:0] bweb; // Active low
	} store_req_t;

endpackage

// ==== logic/ex_control.sv ====
`timescale 1ns/1ps

module ex_control (
	input  logic                     clk,
	input  logic                     rst,
	input  ex_stage_pkg::ex_ctrl_t   ctrl,
	input  logic [31:0]              alu_out,
	input  logic [31:0]              mul_out,
	input  logic [31:0]              pc,
	output logic                     a_sel,
	output logic                     b_sel,
	output rv_isa_pkg::alu_op_e      alu_op,
	output ex_stage_pkg::mem_stage_t mem
);
	import rv_isa_pkg::*;
	import ex_stage_pkg::*;

	result_sel_e result_sel;
	logic [31:0] result;

	always_comb begin
		a_sel = 1'b0;
		b_sel = 1'b0;
		alu_op = ctrl.alu_op;
		result_sel = res_alu;
		case (ctrl.cls)
			cls_alu_ri, cls_lui: begin
				b_sel = 1'b1;
			end
			cls_auipc: begin
				a_sel = 1'b1;
				b_sel = 1'b1;
				alu_op = alu_add;
			end
			cls_jal_link: begin
				a_sel = 1'b1;
				result_sel = res_link;
			end
			cls_mul: begin
				result_sel = res_mul;
			end
			cls_load, cls_store: begin
				b_sel = 1'b1; // Address is rs1 + imm
				alu_op = alu_add;
			end
			default: begin
			end
		endcase
	end

	always_comb begin
		case (result_sel)
			res_mul:  result = mul_out;
			res_link: result = pc + 32'd4;
			default:  result = alu_out;
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			mem.result <= 32'd0;
			mem.rd <= 5'd0;
			mem.wb_en <= 1'b0;
			mem.load <= ld_none;
		end else begin
			mem.result <= result;
			mem.rd <= ctrl.rd;
			mem.wb_en <= ctrl.wb_en;
			mem.load <= ctrl.load;
		end
	end

endmodule

// ==== logic/operand_select.sv ====
`timescale 1ns/1ps

module operand_select (
	input  ex_stage_pkg::ex_operands_t ops,
	input  ex_stage_pkg::fwd_sel_e     fwd_a,
	input  ex_stage_pkg::fwd_sel_e     fwd_b,
	input  logic                       a_sel,
	input  logic                       b_sel,
	output logic [31:0]                reg_a,
	output logic [31:0]                reg_b,
	output logic [31:0]                src_a,
	output logic [31:0]                src_b
);
	import ex_stage_pkg::*;

	// Same bypass choice for both sources
	function automatic logic [31:0] fwd_pick(
		input fwd_sel_e     sel,
		input logic [31:0]  reg_val,
		input ex_operands_t o
	);
		case (sel)
			fwd_mem: fwd_pick = o.fwd_mem;
			fwd_wb:  fwd_pick = o.fwd_wb;
			default: fwd_pick = reg_val;
		endcase
	endfunction

	assign reg_a = fwd_pick(fwd_a, ops.rs1_data, ops);
	assign reg_b = fwd_pick(fwd_b, ops.rs2_data, ops);

	assign src_a = a_sel ? ops.pc : reg_a;   // AUIPC, JAL
	assign src_b = b_sel ? ops.imm : reg_b;

endmodule

// ==== logic/int_alu.sv ====
`timescale 1ns/1ps

module int_alu (
	input  rv_isa_pkg::alu_op_e op,
	input  logic [31:0]         src_a,
	input  logic [31:0]         src_b,
	output logic [31:0]         result
);
	import rv_isa_pkg::*;

	logic [4:0] shamt;
	logic       lt_signed;
	logic       lt_unsigned;

	assign shamt = src_b[4:0];
	assign lt_signed = $signed(src_a) < $signed(src_b);
	assign lt_unsigned = src_a < src_b;

	always_comb begin
		case (op)
			alu_add: begin
				result = src_a + src_b;
			end
			alu_sub: begin
				result = src_a - src_b;
			end
			alu_sll: begin
				result = src_a << shamt;
			end
			alu_slt: begin
				result = {31'd0, lt_signed};
			end
			alu_sltu: begin
				result = {31'd0, lt_unsigned};
			end
			alu_xor: begin
				result = src_a ^ src_b;
			end
			alu_srl: begin
				result = src_a >> shamt;
			end
			alu_sra: begin
				result = $signed(src_a) >>> shamt; // Keeps sign bit
			end
			alu_or: begin
				result = src_a | src_b;
			end
			alu_and: begin
				result = src_a & src_b;
			end
			alu_pass_b: begin
				result = src_b;
			end
			default: begin
				result = 32'd0;
			end
		endcase
	end

endmodule

// ==== logic/int_multiplier.sv ====
`timescale 1ns/1ps

module int_multiplier (
	input  rv_isa_pkg::mul_op_e op,
	input  logic [31:0]         reg_a,
	input  logic [31:0]         reg_b,
	output logic [31:0]         result
);
	import rv_isa_pkg::*;

	logic               a_signed;
	logic               b_signed;
	logic signed [32:0] a_ext;
	logic signed [32:0] b_ext;
	logic signed [63:0] product;

	// MULHSU treats only rs1 as signed
	assign a_signed = (op == m_mulh) || (op == m_mulhsu);
	assign b_signed = (op == m_mulh);

	// Extra top bit turns the unsigned case into a positive signed value
	assign a_ext = {a_signed & reg_a[31], reg_a};
	assign b_ext = {b_signed & reg_b[31], reg_b};

	assign product = a_ext * b_ext;

	always_comb begin
		case (op)
			m_mul:   result = product[31:0];
			default: result = product[63:32]; // High word
		endcase
	end

endmodule

// ==== logic/branch_compare.sv ====
`timescale 1ns/1ps

module branch_compare (
	input  rv_isa_pkg::branch_e kind,
	input  logic [31:0]         reg_a,
	input  logic [31:0]         reg_b,
	output logic                taken
);
	import rv_isa_pkg::*;

	logic eq;
	logic lt;
	logic ltu;

	assign eq = reg_a == reg_b;
	assign lt = $signed(reg_a) < $signed(reg_b);
	assign ltu = reg_a < reg_b;

	always_comb begin
		case (kind)
			br_eq:   taken = eq;
			br_ne:   taken = !eq;
			br_lt:   taken = lt;
			br_ge:   taken = !lt;
			br_ltu:  taken = ltu;
			br_geu:  taken = !ltu;
			default: taken = 1'b0; // Not a branch
		endcase
	end

endmodule

// ==== logic/store_align.sv ====
`timescale 1ns/1ps

module store_align (
	input  rv_isa_pkg::store_e        kind,
	input  logic [31:0]               addr,
	input  logic [31:0]               data,
	output ex_stage_pkg::store_req_t  store
);
	import rv_isa_pkg::*;

	logic [1:0] lane;
	logic [3:0] size_be;
	logic [3:0] lane_be;

	assign lane = addr[1:0];

	always_comb begin
		case (kind)
			st_sb:   size_be = 4'b0001;
			st_sh:   size_be = 4'b0011;
			st_sw:   size_be = 4'b1111;
			default: size_be = 4'b0000; // No store, mask stays all ones
		endcase
	end

	// Bytes past lane 3 fall off the top
	assign lane_be = size_be << lane;

	always_comb begin
		store.addr = addr;
		store.data = data << {lane, 3'b000};
		for (int i = 0; i < 4; i++) begin
			store.bweb[8*i +: 8] = {8{~lane_be[i]}};
		end
	end

endmodule

// ==== logic/ex_mem_stage.sv ====
`timescale 1ns/1ps

module ex_mem_stage (
	input  logic                       clk,
	input  logic                       rst,
	input  ex_stage_pkg::ex_ctrl_t     ctrl,
	input  ex_stage_pkg::ex_operands_t ops,
	output logic                       taken,
	output ex_stage_pkg::store_req_t   store,
	output ex_stage_pkg::mem_stage_t   mem
);
	import rv_isa_pkg::*;

	logic        a_sel;
	logic        b_sel;
	alu_op_e     alu_op;
	logic [31:0] reg_a;
	logic [31:0] reg_b;
	logic [31:0] src_a;
	logic [31:0] src_b;
	logic [31:0] alu_out;
	logic [31:0] mul_out;

	ex_control u_control (
		.clk     (clk),
		.rst     (rst),
		.ctrl    (ctrl),
		.alu_out (alu_out),
		.mul_out (mul_out),
		.pc      (ops.pc),
		.a_sel   (a_sel),
		.b_sel   (b_sel),
		.alu_op  (alu_op),
		.mem     (mem)
	);

	operand_select u_operands (
		.ops   (ops),
		.fwd_a (ctrl.fwd_a),
		.fwd_b (ctrl.fwd_b),
		.a_sel (a_sel),
		.b_sel (b_sel),
		.reg_a (reg_a),
		.reg_b (reg_b),
		.src_a (src_a),
		.src_b (src_b)
	);

	int_alu u_alu (
		.op     (alu_op),
		.src_a  (src_a),
		.src_b  (src_b),
		.result (alu_out)
	);

	// Multiply and compare work on register values, not substituted ones
	int_multiplier u_mul (
		.op     (ctrl.mul_op),
		.reg_a  (reg_a),
		.reg_b  (reg_b),
		.result (mul_out)
	);

	branch_compare u_branch (
		.kind  (ctrl.branch),
		.reg_a (reg_a),
		.reg_b (reg_b),
		.taken (taken)
	);

	store_align u_store (
		.kind  (ctrl.store),
		.addr  (alu_out),
		.data  (reg_b),
		.store (store)
	);

endmodule

// ==== dv/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen (
	output logic clk,
	output logic rst
);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk; // 8 ns period
	end

	initial begin
		rst = 1'b1;
		repeat (4) @(posedge clk);
		rst <= 1'b0;
	end

endmodule

// ==== dv/ex_mem_checker.sv ====
`timescale 1ns/1ps

module ex_mem_checker (
	input logic                     clk,
	input logic                     rst,
	input ex_stage_pkg::ex_ctrl_t   ctrl,
	input ex_stage_pkg::store_req_t store,
	input ex_stage_pkg::mem_stage_t mem
);
	import rv_isa_pkg::*;

	int failures = 0; // Read by the testbench at the end

	wb_en_low_in_reset: assert property (
		@(posedge clk) rst |-> !mem.wb_en
	) else begin
		$error("mem.wb_en is set while reset is asserted");
		failures++;
	end

	// No store means no byte gets written
	mask_idle_without_store: assert property (
		@(posedge clk) (ctrl.store == st_none) |-> (store.bweb == '1)
	) else begin
		$error("store mask is not all ones with no store requested");
		failures++;
	end

	rd_one_cycle_later: assert property (
		@(posedge clk) disable iff (rst) mem.rd == $past(ctrl.rd)
	) else begin
		$error("mem.rd does not hold the rd of the previous cycle");
		failures++;
	end

endmodule

// ==== dv/tb_ex_mem.sv ====
`timescale 1ns/1ps

module tb_ex_mem;
	import rv_isa_pkg::*;
	import ex_stage_pkg::*;

	logic         clk;
	logic         rst;
	ex_ctrl_t     ctrl;
	ex_operands_t ops;
	logic         taken;
	store_req_t   store;
	mem_stage_t   mem;

	int         errors;
	int         tests;
	logic       prev_valid;
	mem_stage_t prev_exp;
	string      prev_name;

	tb_clock_gen u_clk (
		.clk (clk),
		.rst (rst)
	);

	ex_mem_stage u_dut (
		.clk   (clk),
		.rst   (rst),
		.ctrl  (ctrl),
		.ops   (ops),
		.taken (taken),
		.store (store),
		.mem   (mem)
	);

	bind ex_mem_stage ex_mem_checker u_checker (
		.clk   (clk),
		.rst   (rst),
		.ctrl  (ctrl),
		.store (store),
		.mem   (mem)
	);

	function automatic logic [31:0] alu_model(alu_op_e op, logic [31:0] a, logic [31:0] b);
		logic [63:0] ext;
		ext = {{32{a[31]}}, a} >> b[4:0];
		case (op)
			alu_add:    return a + b;
			alu_sub:    return a + ~b + 32'd1;
			alu_sll:    return a << b[4:0];
			alu_slt:    return (a[31] != b[31]) ? {31'd0, a[31]} : {31'd0, a < b};
			alu_sltu:   return {31'd0, a < b};
			alu_xor:    return a ^ b;
			alu_srl:    return a >> b[4:0];
			alu_sra:    return ext[31:0];
			alu_or:     return a | b;
			alu_and:    return a & b;
			alu_pass_b: return b;
			default:    return 32'd0;
		endcase
	endfunction

	function automatic logic [31:0] mul_model(mul_op_e op, logic [31:0] a, logic [31:0] b);
		logic [63:0] p;
		longint      a_s;
		longint      b_s;
		a_s = longint'($signed(a));
		b_s = longint'($signed(b));
		case (op)
			m_mulh:   p = a_s * b_s;
			m_mulhsu: p = a_s * longint'({32'd0, b});
			default:  p = {32'd0, a} * {32'd0, b};
		endcase
		return (op == m_mul) ? p[31:0] : p[63:32];
	endfunction

	function automatic logic branch_model(branch_e kind, logic [31:0] a, logic [31:0] b);
		case (kind)
			br_eq:   return a == b;
			br_ne:   return a != b;
			br_lt:   return $signed(a) < $signed(b);
			br_ge:   return $signed(a) >= $signed(b);
			br_ltu:  return a < b;
			br_geu:  return a >= b;
			default: return 1'b0;
		endcase
	endfunction

	function automatic store_req_t store_model(store_e kind, logic [31:0] addr, logic [31:0] data);
		store_req_t s;
		int         bytes;
		int         lane;
		lane = int'(addr[1:0]);
		case (kind)
			st_sb:   bytes = 1;
			st_sh:   bytes = 2;
			st_sw:   bytes = 4;
			default: bytes = 0;
		endcase
		s.addr = addr;
		s.data = data << (8 * lane);
		s.bweb = '1;
		for (int i = lane; i < lane + bytes && i < 4; i++) begin
			s.bweb[8*i +: 8] = 8'h00; // Lanes past 3 are dropped
		end
		return s;
	endfunction

	function automatic logic [31:0] fwd_value(fwd_sel_e sel, logic [31:0] reg_val, ex_operands_t o);
		if (sel == fwd_mem)
			return o.fwd_mem;
		if (sel == fwd_wb)
			return o.fwd_wb;
		return reg_val;
	endfunction

	function automatic ex_ctrl_t nop_ctrl();
		ex_ctrl_t c;
		c.cls = cls_alu_rr;
		c.alu_op = alu_add;
		c.mul_op = m_mul;
		c.branch = br_none;
		c.load = ld_none;
		c.store = st_none;
		c.fwd_a = fwd_reg;
		c.fwd_b = fwd_reg;
		c.rd = 5'd0;
		c.wb_en = 1'b0;
		return c;
	endfunction

	function automatic ex_operands_t rand_ops();
		ex_operands_t o;
		o = {$urandom(), $urandom(), $urandom(), $urandom(), $urandom(), $urandom()};
		o.pc[1:0] = 2'b00;
		return o;
	endfunction

	task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
		assert (act === exp) else begin
			$display("Fail %s: expected %h, actual %h", name, exp, act);
			errors++;
		end
	endtask

	// Drives one instruction and checks the one registered before it
	task automatic step(input string name, input ex_ctrl_t c, input ex_operands_t o,
			input logic [31:0] result);
		@(posedge clk);
		ctrl <= c;
		ops <= o;
		@(negedge clk);
		if (prev_valid) begin
			check_value({prev_name, " result"}, prev_exp.result, mem.result);
			check_value({prev_name, " rd"}, 32'(prev_exp.rd), 32'(mem.rd));
			check_value({prev_name, " wb_en"}, 32'(prev_exp.wb_en), 32'(mem.wb_en));
			check_value({prev_name, " load"}, 32'(prev_exp.load), 32'(mem.load));
		end
		prev_exp = '{result, c.rd, c.wb_en, c.load};
		prev_name = name;
		prev_valid = 1'b1;
	endtask

	task automatic end_test(input string name, input int start_errors);
		step("drain", nop_ctrl(), '0, 32'd0); // Flushes the last result out
		tests++;
		$display("Test %s finished with %0d errors", name, errors - start_errors);
	endtask

	task automatic check_reset_state(input string name);
		check_value({name, " wb_en"}, 32'd0, 32'(mem.wb_en));
		check_value({name, " load"}, 32'(ld_none), 32'(mem.load));
		check_value({name, " result"}, 32'd0, mem.result);
	endtask

	task automatic test_reset();
		int start;
		int n;
		start = errors;
		@(posedge clk); // First edge applies reset to the register
		@(negedge clk);
		check_reset_state("reset held");
		n = 0;
		while (rst && n < 20) begin
			@(negedge clk);
			n++;
		end
		if (rst) begin
			$display("Reset was still asserted after 20 cycles");
			$display("Regression failed");
			$finish;
		end else begin
			check_reset_state("reset released");
			tests++;
			$display("Test reset finished with %0d errors", errors - start);
		end
	endtask

	task automatic test_alu_forward();
		ex_ctrl_t     c;
		ex_operands_t o;
		logic [31:0]  a;
		logic [31:0]  b;
		int           start;
		start = errors;
		for (int op = 0; op <= 10; op++) begin
			for (int i = 0; i < 9; i++) begin
				o = rand_ops();
				c = nop_ctrl();
				c.alu_op = alu_op_e'(op);
				c.fwd_a = fwd_sel_e'(i / 3);
				c.fwd_b = fwd_sel_e'(i % 3);
				c.rd = 5'($urandom);
				c.wb_en = 1'b1;
				a = fwd_value(c.fwd_a, o.rs1_data, o);
				b = fwd_value(c.fwd_b, o.rs2_data, o);
				step($sformatf("alu %s", c.alu_op.name()), c, o, alu_model(c.alu_op, a, b));
			end
			o = rand_ops();
			c.cls = cls_alu_ri; // Immediate replaces rs2
			c.fwd_a = fwd_reg;
			step("alu imm", c, o, alu_model(c.alu_op, o.rs1_data, o.imm));
		end
		end_test("alu_forward", start);
	endtask

	task automatic test_multiply();
		logic [31:0]  corners [5];
		ex_ctrl_t     c;
		ex_operands_t o;
		int           start;
		corners = '{32'h8000_0000, 32'hffff_ffff, 32'h0000_0000, 32'h0000_0001, 32'h7fff_ffff};
		start = errors;
		for (int op = 0; op < 4; op++) begin
			for (int i = 0; i < 33; i++) begin
				o = rand_ops();
				if (i < 25) begin
					o.rs1_data = corners[i / 5];
					o.rs2_data = corners[i % 5];
				end
				c = nop_ctrl();
				c.cls = cls_mul;
				c.mul_op = mul_op_e'(op);
				c.rd = 5'($urandom);
				c.wb_en = 1'b1;
				step($sformatf("mul %s", c.mul_op.name()), c, o,
					mul_model(c.mul_op, o.rs1_data, o.rs2_data));
			end
		end
		end_test("multiply", start);
	endtask

	task automatic test_branches();
		branch_e      kinds [7];
		logic [31:0]  pa [6];
		logic [31:0]  pb [6];
		logic [31:0]  x;
		ex_ctrl_t     c;
		ex_operands_t o;
		string        name;
		int           start;
		kinds = '{br_none, br_eq, br_ne, br_lt, br_ge, br_ltu, br_geu};
		x = $urandom;
		pa = '{x, 32'hffff_fff0, 32'h0000_0005, 32'h8000_0000, 32'h0000_0001, $urandom};
		pb = '{x, 32'h0000_0005, 32'hffff_fff0, 32'h0000_0001, 32'h8000_0000, $urandom};
		start = errors;
		for (int p = 0; p < 6; p++) begin
			for (int k = 0; k < 7; k++) begin
				o = rand_ops();
				o.rs1_data = pa[p];
				o.rs2_data = pb[p];
				c = nop_ctrl();
				c.cls = cls_branch;
				c.branch = kinds[k];
				c.alu_op = alu_sub;
				name = $sformatf("branch %s pair %0d", kinds[k].name(), p);
				step(name, c, o, alu_model(alu_sub, pa[p], pb[p]));
				check_value({name, " taken"}, 32'(branch_model(kinds[k], pa[p], pb[p])),
					32'(taken));
			end
		end
		end_test("branches", start);
	endtask

	task automatic test_stores();
		store_e       kinds [4];
		store_req_t   exp;
		logic [31:0]  addr;
		ex_ctrl_t     c;
		ex_operands_t o;
		string        name;
		int           start;
		kinds = '{st_none, st_sb, st_sh, st_sw};
		start = errors;
		for (int k = 0; k < 4; k++) begin
			for (int lane = 0; lane < 4; lane++) begin
				o = rand_ops();
				o.rs1_data[1:0] = 2'b00;
				o.imm[1:0] = 2'(lane);
				addr = o.rs1_data + o.imm;
				c = nop_ctrl();
				c.cls = cls_store;
				c.store = kinds[k];
				c.alu_op = alu_xor; // Control must still add
				name = $sformatf("store %s lane %0d", kinds[k].name(), lane);
				step(name, c, o, addr);
				exp = store_model(kinds[k], addr, o.rs2_data);
				check_value({name, " addr"}, exp.addr, store.addr);
				check_value({name, " data"}, exp.data, store.data);
				check_value({name, " bweb"}, exp.bweb, store.bweb);
			end
		end
		end_test("stores", start);
	endtask

	task automatic test_immediates();
		ex_ctrl_t     c;
		ex_operands_t o;
		int           start;
		start = errors;
		for (int i = 0; i < 4; i++) begin
			o = rand_ops();
			c = nop_ctrl();
			c.rd = 5'($urandom);
			c.wb_en = 1'b1;
			c.cls = cls_lui;
			c.alu_op = alu_pass_b;
			step("lui", c, o, o.imm);
			c.cls = cls_auipc;
			c.alu_op = alu_or;
			step("auipc", c, o, o.pc + o.imm);
			c.cls = cls_jal_link;
			step("jal_link", c, o, o.pc + 32'd4);
		end
		for (int ld = 1; ld <= 5; ld++) begin
			o = rand_ops();
			c = nop_ctrl();
			c.cls = cls_load;
			c.load = load_e'(ld);
			c.rd = 5'($urandom);
			c.wb_en = 1'b1;
			step($sformatf("load %s", c.load.name()), c, o, o.rs1_data + o.imm);
		end
		end_test("immediates", start);
	endtask

	initial begin
		void'($urandom(32'hfcdab028));
		ctrl = nop_ctrl();
		ops = '0;
		errors = 0;
		tests = 0;
		prev_valid = 1'b0;
		test_reset();
		test_alu_forward();
		test_multiply();
		test_branches();
		test_stores();
		test_immediates();
		errors += u_dut.u_checker.failures; // Bound assertion failures
		$display("Tests run: %0d, failed checks: %0d", tests, errors);
		if (errors == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

// ==== verilog.f ====
logic/rv_isa_pkg.sv
logic/ex_stage_pkg.sv
logic/ex_control.sv
logic/operand_select.sv
logic/int_alu.sv
logic/int_multiplier.sv
logic/branch_compare.sv
logic/store_align.sv
logic/ex_mem_stage.sv
dv/tb_clock_gen.sv
dv/ex_mem_checker.sv
dv/tb_ex_mem.sv
